// File: common/agen_pkg.sv
package agen_pkg;

  typedef logic [31:0]        addr_t;    // byte address or byte offset
  typedef logic signed [31:0] stride_t;  // signed byte stride
  typedef logic [15:0]        len_t;     // dimension length in beats
  typedef logic [23:0]        tot_t;     // total beats in a run
  typedef logic [2:0]         dim_en_t;  // bit0 d1, bit1 d2, bit2 d3
  typedef logic [3:0]         cfg_sel_t; // register select on the cfg port

  // register select codes
  localparam cfg_sel_t SEL_BASE      = 4'h0;
  localparam cfg_sel_t SEL_TOT       = 4'h1;
  localparam cfg_sel_t SEL_D0_LEN    = 4'h2;
  localparam cfg_sel_t SEL_D1_LEN    = 4'h3;
  localparam cfg_sel_t SEL_D2_LEN    = 4'h4;
  localparam cfg_sel_t SEL_D0_STRIDE = 4'h5;
  localparam cfg_sel_t SEL_D1_STRIDE = 4'h6;
  localparam cfg_sel_t SEL_D2_STRIDE = 4'h7;
  localparam cfg_sel_t SEL_D3_STRIDE = 4'h8;
  localparam cfg_sel_t SEL_DIM_EN    = 4'h9;
  localparam cfg_sel_t SEL_START     = 4'hA; // launches a run when idle

  // run sequencer: clear, presample, then run until drained
  typedef enum logic [1:0] {
    IDLE,
    CLEAR,
    PRESAMPLE,
    RUN
  } loader_state_t;

endpackage

// File: common/agen_cfg_if.sv
`timescale 1ns/10ps

interface agen_cfg_if;

  agen_pkg::addr_t   base;      // stream base address
  agen_pkg::tot_t    tot;       // beats per run
  agen_pkg::len_t    d0_len;
  agen_pkg::len_t    d1_len;
  agen_pkg::len_t    d2_len;
  agen_pkg::stride_t d0_stride;
  agen_pkg::stride_t d1_stride;
  agen_pkg::stride_t d2_stride;
  agen_pkg::stride_t d3_stride;
  agen_pkg::dim_en_t dim_en;    // dimension enable mask
  logic              clear;     // one cycle, resets counters
  logic              presample; // one cycle, primes first beat
  logic              enable;    // counters may step

  modport regs (
    output base, tot, d0_len, d1_len, d2_len,
    output d0_stride, d1_stride, d2_stride, d3_stride,
    output dim_en, clear, presample, enable
  );

  modport gen (
    input base, tot, d0_len, d1_len, d2_len,
    input d0_stride, d1_stride, d2_stride, d3_stride,
    input dim_en, clear, presample, enable
  );

endinterface

// File: rtl/agen_cfg_regs.sv
`timescale 1ns/10ps

module agen_cfg_regs (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               cfg_req_i,    // four-phase request
  output logic               cfg_ack_o,    // four-phase acknowledge
  input  agen_pkg::cfg_sel_t cfg_sel_i,
  input  agen_pkg::addr_t    cfg_wdata_i,
  input  logic               gen_done_i,   // generator reached tot
  input  logic               fifo_empty_i, // last beat popped
  output logic               busy_o,
  agen_cfg_if.regs           cfg_o
);

  logic                    ack_q;
  logic                    wr_stb;  // first cycle req seen with ack low
  logic                    wr_en;   // write accepted, idle only
  agen_pkg::loader_state_t state_q, state_d;

  agen_pkg::addr_t   base_q;
  agen_pkg::tot_t    tot_q;
  agen_pkg::len_t    d0_len_q, d1_len_q, d2_len_q;
  agen_pkg::stride_t d0_stride_q, d1_stride_q, d2_stride_q, d3_stride_q;
  agen_pkg::dim_en_t dim_en_q;

  assign wr_stb = cfg_req_i & ~ack_q;
  assign wr_en  = wr_stb & (state_q == agen_pkg::IDLE); // busy writes get ack, no store

  // four-phase slave, ack follows req by one cycle both ways
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else if (wr_stb) begin
      ack_q <= 1'b1;
    end else if (ack_q && !cfg_req_i) begin
      ack_q <= 1'b0;
    end
  end

  // geometry registers, truncated to their widths
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      base_q      <= '0;
      tot_q       <= '0;
      d0_len_q    <= '0;
      d1_len_q    <= '0;
      d2_len_q    <= '0;
      d0_stride_q <= '0;
      d1_stride_q <= '0;
      d2_stride_q <= '0;
      d3_stride_q <= '0;
      dim_en_q    <= '0;
    end else if (wr_en) begin
      case (cfg_sel_i)
        agen_pkg::SEL_BASE:      base_q      <= cfg_wdata_i;
        agen_pkg::SEL_TOT:       tot_q       <= agen_pkg::tot_t'(cfg_wdata_i);
        agen_pkg::SEL_D0_LEN:    d0_len_q    <= agen_pkg::len_t'(cfg_wdata_i);
        agen_pkg::SEL_D1_LEN:    d1_len_q    <= agen_pkg::len_t'(cfg_wdata_i);
        agen_pkg::SEL_D2_LEN:    d2_len_q    <= agen_pkg::len_t'(cfg_wdata_i);
        agen_pkg::SEL_D0_STRIDE: d0_stride_q <= agen_pkg::stride_t'(cfg_wdata_i);
        agen_pkg::SEL_D1_STRIDE: d1_stride_q <= agen_pkg::stride_t'(cfg_wdata_i);
        agen_pkg::SEL_D2_STRIDE: d2_stride_q <= agen_pkg::stride_t'(cfg_wdata_i);
        agen_pkg::SEL_D3_STRIDE: d3_stride_q <= agen_pkg::stride_t'(cfg_wdata_i);
        agen_pkg::SEL_DIM_EN:    dim_en_q    <= agen_pkg::dim_en_t'(cfg_wdata_i);
        default: ; // start and unused codes store nothing
      endcase
    end
  end

  // run sequencer
  always_comb begin
    state_d = state_q;
    case (state_q)
      agen_pkg::IDLE: begin
        if (wr_stb && cfg_sel_i == agen_pkg::SEL_START) begin
          state_d = agen_pkg::CLEAR; // clear lands with ack rising
        end
      end
      agen_pkg::CLEAR:     state_d = agen_pkg::PRESAMPLE;
      agen_pkg::PRESAMPLE: state_d = agen_pkg::RUN;
      agen_pkg::RUN: begin
        if (gen_done_i && fifo_empty_i) begin
          state_d = agen_pkg::IDLE; // all beats generated and popped
        end
      end
      default: state_d = agen_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= agen_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign cfg_ack_o = ack_q;
  assign busy_o    = (state_q != agen_pkg::IDLE);

  assign cfg_o.base      = base_q;
  assign cfg_o.tot       = tot_q;
  assign cfg_o.d0_len    = d0_len_q;
  assign cfg_o.d1_len    = d1_len_q;
  assign cfg_o.d2_len    = d2_len_q;
  assign cfg_o.d0_stride = d0_stride_q;
  assign cfg_o.d1_stride = d1_stride_q;
  assign cfg_o.d2_stride = d2_stride_q;
  assign cfg_o.d3_stride = d3_stride_q;
  assign cfg_o.dim_en    = dim_en_q;
  assign cfg_o.clear     = (state_q == agen_pkg::CLEAR);
  assign cfg_o.presample = (state_q == agen_pkg::PRESAMPLE);
  assign cfg_o.enable    = (state_q == agen_pkg::PRESAMPLE) |
                           ((state_q == agen_pkg::RUN) & ~gen_done_i); // drops at gen done

  // running geometry is frozen for the whole run, busy writes included
  a_geom_frozen: assert property (@(posedge clk_i) disable iff (!rst_ni)
    busy_o |=> $stable({base_q, tot_q, d0_len_q, d1_len_q, d2_len_q,
                        d0_stride_q, d1_stride_q, d2_stride_q, d3_stride_q, dim_en_q}));

endmodule

// File: addrgen/addrgen_4d.sv
`timescale 1ns/10ps

module addrgen_4d #(
  parameter int unsigned CNT           = 16,     // width of dimension counters
  parameter int unsigned TRANS_CNT     = 24,     // width of overall counter
  parameter bit [2:0]    DIM_ENABLE_1H = 3'b111  // dimensions built in hw
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  agen_cfg_if.gen         cfg_i,
  output logic            addr_valid_o,
  input  logic            addr_ready_i,
  output agen_pkg::addr_t addr_data_o,
  output logic            gen_done_o
);

  logic [2:0]           dim_on;    // sw mask and hw cap combined
  logic                 step;      // presample or an accepted beat
  logic [CNT-1:0]       d0_len_w, d1_len_w, d2_len_w;
  logic [TRANS_CNT-1:0] tot_w;

  logic [CNT-1:0]       d0_cnt_q, d1_cnt_q, d2_cnt_q;
  logic [CNT-1:0]       d0_cnt_d, d1_cnt_d, d2_cnt_d;
  agen_pkg::addr_t      d0_off_q, d1_off_q, d2_off_q, d3_off_q; // partial offsets
  agen_pkg::addr_t      d0_off_d, d1_off_d, d2_off_d, d3_off_d;
  logic [TRANS_CNT-1:0] ov_cnt_q, ov_cnt_d;                      // beats primed so far
  logic                 valid_q, valid_d;

  assign dim_on   = cfg_i.dim_en & DIM_ENABLE_1H;
  assign d0_len_w = CNT'(cfg_i.d0_len);
  assign d1_len_w = CNT'(cfg_i.d1_len);
  assign d2_len_w = CNT'(cfg_i.d2_len);
  assign tot_w    = TRANS_CNT'(cfg_i.tot);
  assign step     = cfg_i.presample | (valid_q & addr_ready_i); // one beat per cycle max

  // next counter state, innermost dimension first
  always_comb begin
    d0_off_d = d0_off_q;
    d1_off_d = d1_off_q;
    d2_off_d = d2_off_q;
    d3_off_d = d3_off_q;
    d0_cnt_d = d0_cnt_q;
    d1_cnt_d = d1_cnt_q;
    d2_cnt_d = d2_cnt_q;
    ov_cnt_d = ov_cnt_q;
    valid_d  = valid_q;
    if (step) begin
      if (ov_cnt_q < tot_w) begin
        valid_d = 1'b1;
        if ((d0_cnt_q < d0_len_w) || !dim_on[0]) begin
          d0_off_d = d0_off_q + agen_pkg::addr_t'(cfg_i.d0_stride);
          d0_cnt_d = d0_cnt_q + 1'b1;
        end else if ((d1_cnt_q < d1_len_w) || !dim_on[1]) begin
          d0_off_d = '0;                                          // d0 wraps
          d1_off_d = d1_off_q + agen_pkg::addr_t'(cfg_i.d1_stride);
          d0_cnt_d = CNT'(1);
          d1_cnt_d = d1_cnt_q + 1'b1;
        end else if ((d2_cnt_q < d2_len_w) || !dim_on[2]) begin
          d0_off_d = '0;                                          // d0, d1 wrap
          d1_off_d = '0;
          d2_off_d = d2_off_q + agen_pkg::addr_t'(cfg_i.d2_stride);
          d0_cnt_d = CNT'(1);
          d1_cnt_d = CNT'(1);
          d2_cnt_d = d2_cnt_q + 1'b1;
        end else begin
          d0_off_d = '0;                                          // d3 has no limit
          d1_off_d = '0;
          d2_off_d = '0;
          d3_off_d = d3_off_q + agen_pkg::addr_t'(cfg_i.d3_stride);
          d0_cnt_d = CNT'(1);
          d1_cnt_d = CNT'(1);
          d2_cnt_d = CNT'(1);
        end
        ov_cnt_d = ov_cnt_q + 1'b1;
      end else begin
        valid_d = 1'b0; // last beat taken
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      d0_off_q <= '0;
      d1_off_q <= '0;
      d2_off_q <= '0;
      d3_off_q <= '0;
      d0_cnt_q <= '0;
      d1_cnt_q <= CNT'(1);
      d2_cnt_q <= CNT'(1);
      ov_cnt_q <= '0;
      valid_q  <= 1'b0;
    end else if (cfg_i.clear) begin
      d0_off_q <= '0;
      d1_off_q <= '0;
      d2_off_q <= '0;
      d3_off_q <= '0;
      d0_cnt_q <= '0;      // presample brings d0 to 1
      d1_cnt_q <= CNT'(1);
      d2_cnt_q <= CNT'(1);
      ov_cnt_q <= '0;
      valid_q  <= 1'b0;
    end else if (cfg_i.enable) begin
      d0_off_q <= cfg_i.presample ? '0 : d0_off_d; // first beat sits at offset zero
      d1_off_q <= d1_off_d;
      d2_off_q <= d2_off_d;
      d3_off_q <= d3_off_d;
      d0_cnt_q <= d0_cnt_d;
      d1_cnt_q <= d1_cnt_d;
      d2_cnt_q <= d2_cnt_d;
      ov_cnt_q <= ov_cnt_d;
      valid_q  <= valid_d;
    end
  end

  assign addr_data_o  = cfg_i.base + d3_off_q + d2_off_q + d1_off_q + d0_off_q;
  assign addr_valid_o = valid_q;
  assign gen_done_o   = (ov_cnt_q == tot_w) & ~valid_q & ~cfg_i.presample;

  // stalled beat must not move
  a_data_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    addr_valid_o && !addr_ready_i |=> $stable(addr_data_o));

  // never more beats than configured
  a_ov_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cfg_i.enable |-> ov_cnt_q <= tot_w);

endmodule

// File: rtl/addr_out_fifo.sv
`timescale 1ns/10ps

module addr_out_fifo #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            in_valid_i,  // from generator
  output logic            in_ready_o,
  input  agen_pkg::addr_t in_data_i,
  output logic            out_valid_o, // to consumer
  input  logic            out_ready_i,
  output agen_pkg::addr_t out_data_o,
  input  logic            gen_done_i,
  input  logic            start_i,     // clear strobe of a new run
  output logic            empty_o,
  output logic            done_o
);

  localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(FIFO_DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(FIFO_DEPTH);

  agen_pkg::addr_t  mem_q [FIFO_DEPTH]; // entry storage
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push, pop;
  logic             armed_q;            // a run has been started

  assign push = in_valid_i & in_ready_o;
  assign pop  = out_valid_o & out_ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_data_i;
    end
  end

  // pointers wrap at the last entry for any depth
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q; // both or neither
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      armed_q <= 1'b0;
    end else if (start_i) begin
      armed_q <= 1'b1; // done holds until the next start
    end
  end

  assign in_ready_o  = (count_q < FULL_CNT);
  assign out_valid_o = (count_q != '0);
  assign out_data_o  = mem_q[rd_ptr_q];
  assign empty_o     = (count_q == '0);
  assign done_o      = armed_q & gen_done_i & empty_o & ~start_i; // low on the start cycle

  // count in range and pointers meet only when empty or full
  a_count_ptr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (count_q <= FULL_CNT) &&
    ((wr_ptr_q == rd_ptr_q) == ((count_q == '0) || (count_q == FULL_CNT))));

endmodule

// File: rtl/agen_top.sv
`timescale 1ns/10ps

module agen_top #(
  parameter int unsigned CNT           = 16,
  parameter int unsigned TRANS_CNT     = 24,
  parameter bit [2:0]    DIM_ENABLE_1H = 3'b111,
  parameter int unsigned FIFO_DEPTH    = 4
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               cfg_req_i,
  output logic               cfg_ack_o,
  input  agen_pkg::cfg_sel_t cfg_sel_i,
  input  agen_pkg::addr_t    cfg_wdata_i,
  output logic               addr_valid_o,
  input  logic               addr_ready_i,
  output agen_pkg::addr_t    addr_data_o,
  output logic               busy_o,
  output logic               done_o
);

  logic            gen_valid;  // generator to fifo
  logic            gen_ready;  // fifo has room
  agen_pkg::addr_t gen_data;
  logic            gen_done;
  logic            fifo_empty;

  agen_cfg_if cfg ();

  agen_cfg_regs i_cfg_regs (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cfg_req_i    (cfg_req_i),
    .cfg_ack_o    (cfg_ack_o),
    .cfg_sel_i    (cfg_sel_i),
    .cfg_wdata_i  (cfg_wdata_i),
    .gen_done_i   (gen_done),
    .fifo_empty_i (fifo_empty),
    .busy_o       (busy_o),
    .cfg_o        (cfg)
  );

  addrgen_4d #(
    .CNT           (CNT),
    .TRANS_CNT     (TRANS_CNT),
    .DIM_ENABLE_1H (DIM_ENABLE_1H)
  ) i_addrgen (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cfg_i        (cfg),
    .addr_valid_o (gen_valid),
    .addr_ready_i (gen_ready),
    .addr_data_o  (gen_data),
    .gen_done_o   (gen_done)
  );

  addr_out_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_out_fifo (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (gen_valid),
    .in_ready_o  (gen_ready),
    .in_data_i   (gen_data),
    .out_valid_o (addr_valid_o),
    .out_ready_i (addr_ready_i),
    .out_data_o  (addr_data_o),
    .gen_done_i  (gen_done),
    .start_i     (cfg.clear), // clear strobe arms done
    .empty_o     (fifo_empty),
    .done_o      (done_o)
  );

endmodule

// File: testbench/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen #(
  parameter int unsigned PERIOD_NS  = 20,
  parameter int unsigned RST_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_no  // active low
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #2 rst_no = 1'b1;  // release off the edge, like other inputs
  end

endmodule

// File: testbench/tb_agen_top.sv
`timescale 1ns/10ps

module tb_agen_top;

  localparam int       NUM_ROWS  = 6;
  localparam int       DRIVE_NS  = 2;      // input skew after the rising edge
  localparam int       ACK_LIMIT = 16;     // cycles allowed per handshake phase
  localparam bit [2:0] HW_DIMS   = 3'b111; // DIM_ENABLE_1H used for dut and model

  typedef struct packed {
    agen_pkg::addr_t   base;
    agen_pkg::tot_t    tot;
    agen_pkg::len_t    d0_len;
    agen_pkg::len_t    d1_len;
    agen_pkg::len_t    d2_len;
    agen_pkg::addr_t   s0;      // strides as raw 32 bit patterns
    agen_pkg::addr_t   s1;
    agen_pkg::addr_t   s2;
    agen_pkg::addr_t   s3;
    agen_pkg::dim_en_t dim_en;
    logic              lfsr_bp; // random ready instead of always ready
    logic              busy_wr; // config writes while the run is active
    logic              wr_cfg;  // 0 reuses the geometry already loaded
  } row_t;

  logic               clk_i;
  logic               rst_ni;
  logic               cfg_req_i;
  logic               cfg_ack_o;
  agen_pkg::cfg_sel_t cfg_sel_i;
  agen_pkg::addr_t    cfg_wdata_i;
  logic               addr_valid_o;
  logic               addr_ready_i;
  agen_pkg::addr_t    addr_data_o;
  logic               busy_o;
  logic               done_o;

  row_t        rows [NUM_ROWS];
  logic [15:0] lfsr_q;
  int          err_cnt;
  int          chk_cnt;
  int          wd_cycles;

  tb_clk_gen #(.PERIOD_NS(20), .RST_CYCLES(4)) clk_gen (.clk_o(clk_i), .rst_no(rst_ni));

  agen_top #(.DIM_ENABLE_1H(HW_DIMS)) dut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cfg_req_i    (cfg_req_i),
    .cfg_ack_o    (cfg_ack_o),
    .cfg_sel_i    (cfg_sel_i),
    .cfg_wdata_i  (cfg_wdata_i),
    .addr_valid_o (addr_valid_o),
    .addr_ready_i (addr_ready_i),
    .addr_data_o  (addr_data_o),
    .busy_o       (busy_o),
    .done_o       (done_o)
  );

  function automatic row_t make_row(input agen_pkg::addr_t base, input int tot,
                                    input int l0, input int l1, input int l2,
                                    input int s0, input int s1, input int s2, input int s3,
                                    input int en, input bit bp, input bit bw, input bit wr);
    row_t r;
    r.base    = base;
    r.tot     = agen_pkg::tot_t'(tot);
    r.d0_len  = agen_pkg::len_t'(l0);
    r.d1_len  = agen_pkg::len_t'(l1);
    r.d2_len  = agen_pkg::len_t'(l2);
    r.s0      = agen_pkg::addr_t'(s0);
    r.s1      = agen_pkg::addr_t'(s1);
    r.s2      = agen_pkg::addr_t'(s2);
    r.s3      = agen_pkg::addr_t'(s3);
    r.dim_en  = agen_pkg::dim_en_t'(en);
    r.lfsr_bp = bp;
    r.busy_wr = bw;
    r.wr_cfg  = wr;
    return r;
  endfunction

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  // base + i3*s3 + i2*s2 + i1*s1 + i0*s0, wraps at 32 bits
  function automatic agen_pkg::addr_t expected_addr(input row_t g, input int i0, input int i1,
                                                    input int i2, input int i3);
    return g.base + agen_pkg::addr_t'(i0) * g.s0 + agen_pkg::addr_t'(i1) * g.s1
                  + agen_pkg::addr_t'(i2) * g.s2 + agen_pkg::addr_t'(i3) * g.s3;
  endfunction

  // nested loop step, a disabled dimension lets the inner index run on
  task automatic advance_index(input row_t g, inout int i0, inout int i1, inout int i2,
                               inout int i3);
    logic [2:0] en;
    en = g.dim_en & HW_DIMS;
    if (!en[0] || i0 + 1 < int'(g.d0_len)) begin
      i0++;
    end else begin
      i0 = 0;
      if (!en[1] || i1 + 1 < int'(g.d1_len)) begin
        i1++;
      end else begin
        i1 = 0;
        if (!en[2] || i2 + 1 < int'(g.d2_len)) begin
          i2++;
        end else begin
          i2 = 0;
          i3++;  // d3 has no limit
        end
      end
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    chk_cnt++;
    if (exp !== act) begin
      err_cnt++;
      $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic next_cycle;
    @(posedge clk_i);
    #DRIVE_NS;  // outputs settled, inputs may change
  endtask

  // four-phase write: req up, wait ack, req down, wait ack low
  task automatic cfg_write(input agen_pkg::cfg_sel_t sel, input agen_pkg::addr_t data);
    int cyc;
    cfg_sel_i   = sel;
    cfg_wdata_i = data;
    cfg_req_i   = 1'b1;
    cyc         = 0;
    do begin
      next_cycle();
      cyc++;
    end while (!cfg_ack_o && cyc < ACK_LIMIT);
    if (!cfg_ack_o) begin
      err_cnt++;
      $display("config write to select %0d was never acknowledged", sel);
    end
    cfg_req_i = 1'b0;
    cyc       = 0;
    while (cfg_ack_o && cyc < ACK_LIMIT) begin
      next_cycle();
      cyc++;
    end
    if (cfg_ack_o) begin
      err_cnt++;
      $display("config ack stayed high after the request was dropped");
    end
  endtask

  task automatic write_geometry(input row_t g);
    cfg_write(agen_pkg::SEL_BASE, g.base);
    cfg_write(agen_pkg::SEL_TOT, 32'(g.tot));
    cfg_write(agen_pkg::SEL_D0_LEN, 32'(g.d0_len));
    cfg_write(agen_pkg::SEL_D1_LEN, 32'(g.d1_len));
    cfg_write(agen_pkg::SEL_D2_LEN, 32'(g.d2_len));
    cfg_write(agen_pkg::SEL_D0_STRIDE, g.s0);
    cfg_write(agen_pkg::SEL_D1_STRIDE, g.s1);
    cfg_write(agen_pkg::SEL_D2_STRIDE, g.s2);
    cfg_write(agen_pkg::SEL_D3_STRIDE, g.s3);
    cfg_write(agen_pkg::SEL_DIM_EN, 32'(g.dim_en));
  endtask

  // garbage geometry once the stream is flowing, must be acked and ignored
  task automatic write_while_busy(input row_t g);
    int cyc;
    cyc = 0;
    while (!addr_valid_o && cyc < ACK_LIMIT) begin
      next_cycle();
      cyc++;
    end
    if (!addr_valid_o) begin
      err_cnt++;
      $display("no beat appeared, so no write could be made during the run");
    end else begin
      check_value("busy_o", 32'd1, 32'(busy_o));
      cfg_write(agen_pkg::SEL_BASE, ~g.base);
      cfg_write(agen_pkg::SEL_D0_STRIDE, 32'h0000_0100);
      cfg_write(agen_pkg::SEL_TOT, 32'd3);
    end
  endtask

  // takes beats until done_o, compares each with the model
  task automatic collect_beats(input row_t g, output int got);
    int   cyc;
    int   lim;
    int   i0, i1, i2, i3;
    logic fin;
    logic rdy;
    got = 0;
    cyc = 0;
    i0  = 0;
    i1  = 0;
    i2  = 0;
    i3  = 0;
    fin = 1'b0;
    lim = 4 * int'(g.tot) + 40;
    while (!fin && cyc < lim) begin
      next_cycle();
      cyc++;
      if (done_o) begin
        fin = 1'b1;
      end else begin
        if (g.lfsr_bp) begin
          lfsr_q = lfsr_next(lfsr_q);  // one step per ready bit
          rdy    = lfsr_q[0];
        end else begin
          rdy = 1'b1;
        end
        addr_ready_i = rdy;
        if (addr_valid_o && rdy) begin  // accepted at the coming edge
          check_value("addr_data_o", expected_addr(g, i0, i1, i2, i3), addr_data_o);
          advance_index(g, i0, i1, i2, i3);
          got++;
        end
      end
    end
    addr_ready_i = 1'b1;
    if (!fin) begin
      err_cnt++;
      $display("done_o did not rise within %0d cycles", lim);
    end
    check_value("beat count", 32'(g.tot), got);
    check_value("addr_valid_o", 32'd0, 32'(addr_valid_o));
    cyc = 0;
    while (busy_o && cyc < ACK_LIMIT) begin
      next_cycle();
      cyc++;
    end
    check_value("busy_o", 32'd0, 32'(busy_o));
    check_value("done_o", 32'd1, 32'(done_o));  // held until next start
  endtask

  task automatic run_row(input int r);
    row_t g;
    int   err0;
    int   got;
    g    = rows[r];
    err0 = err_cnt;
    if (g.wr_cfg) begin
      write_geometry(g);
    end
    cfg_write(agen_pkg::SEL_START, '0);
    check_value("busy_o", 32'd1, 32'(busy_o));
    check_value("done_o", 32'd0, 32'(done_o));
    fork
      collect_beats(g, got);
      begin
        if (g.busy_wr) begin
          write_while_busy(g);
        end
      end
    join
    $display("test %0d %s: %0d beats, dim_en %b, %s ready, %0d errors", r,
             (err_cnt == err0) ? "passed" : "FAILED", got, g.dim_en,
             g.lfsr_bp ? "lfsr" : "always", err_cnt - err0);
  endtask

  task automatic load_table;
    //                base          tot l0 l1 l2  s0   s1     s2     s3 en      bp bw wr
    rows[0] = make_row(32'h0000_1000, 10, 4, 4, 4, 4, 0, 0, 0, 3'b000, 0, 0, 1);
    rows[1] = make_row(32'h2000_0000, 12, 3, 5, 5, 8, -64, 0, 0, 3'b001, 0, 0, 1);
    rows[2] = make_row(32'h0000_8000, 18, 2, 3, 2, 4, 64, -4096, 0, 3'b011, 0, 0, 1);
    rows[3] = make_row(32'hFFFF_FF00, 17, 2, 2, 3, 1, 16, 256, 4096, 3'b111, 0, 0, 1);
    rows[4] = make_row(32'h4000_0000, 20, 3, 2, 2, -4, 32, 512, 16384, 3'b111, 1, 1, 1);
    // rerun without rewriting, busy writes of row 4 must not show up
    rows[5] = make_row(32'h4000_0000, 20, 3, 2, 2, -4, 32, 512, 16384, 3'b111, 1, 0, 0);
  endtask

  initial begin
    cfg_req_i    = 1'b0;
    cfg_sel_i    = '0;
    cfg_wdata_i  = '0;
    addr_ready_i = 1'b1;
    lfsr_q       = 16'd40407;
    err_cnt      = 0;
    chk_cnt      = 0;
    load_table();
    wd_cycles = 10;  // reset and alignment
    for (int r = 0; r < NUM_ROWS; r++) begin
      wd_cycles += 4 * int'(rows[r].tot) + 40;
    end
    wait (rst_ni === 1'b1);
    next_cycle();
    check_value("cfg_ack_o", 32'd0, 32'(cfg_ack_o));
    check_value("addr_valid_o", 32'd0, 32'(addr_valid_o));
    check_value("busy_o", 32'd0, 32'(busy_o));
    check_value("done_o", 32'd0, 32'(done_o));
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(r);
    end
    $display("tests %0d, checks %0d, errors %0d", NUM_ROWS, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // watchdog, budget summed from the table at time zero
  initial begin
    #1;
    repeat (wd_cycles) @(posedge clk_i);
    $display("timeout: the run did not finish within %0d cycles", wd_cycles);
    $display("Done: errors found");
    $finish;
  end

endmodule

// File: src.f
common/agen_pkg.sv
common/agen_cfg_if.sv
rtl/agen_cfg_regs.sv
addrgen/addrgen_4d.sv
rtl/addr_out_fifo.sv
rtl/agen_top.sv
testbench/tb_clk_gen.sv
testbench/tb_agen_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the address generator testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
  --top-module tb_agen_top \
  -Mdir obj_dir \
  -f src.f

./obj_dir/Vtb_agen_top | tee "$LOG"

if grep -q "Done: errors found" "$LOG"; then
  echo "simulation failed, see $LOG"
  exit 1
fi

echo "simulation passed"
